//--- verilog/minibus_pkg.sv
//------------------------------------------------
// shared types, address map and register offsets
// for the 68000 bus bridge. import where needed
//------------------------------------------------

package minibus_pkg;

	//------------------------------------------------
	// widths
	//------------------------------------------------
	typedef logic [23:1] cpu_addr_t;    // 68000 word address
	typedef logic [15:0] word_t;        // data bus word
	typedef logic [18:1] ram_addr_t;    // sram word address, one 512 KB bank
	typedef logic [7:0]  bank_sel_t;    // one-hot bank select
	typedef logic [3:0]  mem_config_t;  // [3:2] slow size, [1:0] chip size
	typedef logic [3:0]  eclk_phase_t;  // e-clock phase 0..9

	// address region seen by the decoder
	typedef enum logic [2:0] {
		RGN_NONE,
		RGN_CHIP,
		RGN_SLOW,
		RGN_KICK,
		RGN_CIA,
		RGN_CUSTOM
	} region_e;

	// bus cycle states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SLOT,       // waiting for a free colour-clock slot
		ST_ECLK_WAIT,  // peripheral cycle, waiting for vma and the e-clock
		ST_ACK         // dtack low until as_n goes away
	} bus_state_e;

	typedef struct packed {
		logic as_n;
		logic uds_n;
		logic lds_n;
		logic r_w;     // 1 = read
	} cpu_ctrl_t;

	typedef struct packed {
		cpu_addr_t addr;
		word_t     wdata;
		logic      rd;   // one-clock strobes
		logic      hwr;
		logic      lwr;
	} bus_req_t;

	typedef struct packed {
		ram_addr_t addr;
		logic      we_n;
		logic      oe_n;
		logic      bhe_n;
		logic      ble_n;
	} ram_ctrl_t;

	//------------------------------------------------
	// address map, top address byte a[23:16]
	//------------------------------------------------
	localparam logic [7:0] ADDR_CHIP_HI   = 8'h1F;  // chip from 00
	localparam logic [7:0] ADDR_SLOW_LO   = 8'hC0;
	localparam logic [7:0] ADDR_SLOW_HI   = 8'hD7;
	localparam logic [7:0] ADDR_CIA       = 8'hBF;
	localparam logic [7:0] ADDR_CUSTOM    = 8'hDF;
	localparam logic [7:0] ADDR_KICK_LO   = 8'hF8;  // kick up to FF

	// custom register offsets
	localparam logic [8:0] REG_JOY0DAT = 9'h00A;
	localparam logic [8:0] REG_JOY1DAT = 9'h00C;
	localparam logic [8:0] REG_POTINP  = 9'h016;
	localparam logic [8:0] REG_POTGO   = 9'h034;

	// e-clock timing
	localparam int          ECLK_PHASES  = 10;
	localparam eclk_phase_t ECLK_VMA_SET = 4'd3;  // vpa sampled here
	localparam eclk_phase_t ECLK_ACK     = 4'd8;  // dtack low during this phase
	localparam eclk_phase_t ECLK_VMA_CLR = 4'd9;

endpackage

//--- verilog/eclk_timer.sv
//------------------------------------------------
// e-clock phase counter and colour-clock slot
// enable, the time base of the bus bridge
//------------------------------------------------
`timescale 1ns/1ps

module eclk_timer (
	input  logic                     clk,
	input  logic                     cpurst,
	output minibus_pkg::eclk_phase_t phase_o,  // 0..9, wraps
	output logic                     cck_o     // high on even phases
);
	import minibus_pkg::*;

	localparam eclk_phase_t LAST_PHASE = eclk_phase_t'(ECLK_PHASES - 1);

	eclk_phase_t phase_q;

	//------------------------------------------------
	// phase counter
	//------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpurst) begin
			phase_q <= '0;
		end else if (phase_q == LAST_PHASE) begin
			phase_q <= '0;  // ten clocks per e-clock period
		end else begin
			phase_q <= phase_q + 4'd1;
		end
	end

	// phase count is even so cck alternates every clock, also across the wrap
	// cck high = dma slot, cpu strobes go in the low half
	assign cck_o   = ~phase_q[0];
	assign phase_o = phase_q;

endmodule

//--- verilog/cpu_bus_fsm.sv
//------------------------------------------------
// 68000 bus cycle bridge: samples as_n, issues one
// internal strobe per cycle and answers with dtack
//------------------------------------------------
`timescale 1ns/1ps

module cpu_bus_fsm (
	input  logic                     clk,
	input  logic                     cpurst,
	input  minibus_pkg::cpu_ctrl_t   cpu_ctrl_i,
	input  minibus_pkg::cpu_addr_t   cpu_addr_i,
	input  minibus_pkg::word_t       cpu_wdata_i,
	input  minibus_pkg::eclk_phase_t phase_i,
	input  logic                     cck_i,
	input  minibus_pkg::region_e     region_i,
	input  minibus_pkg::word_t       mem_rdata_i,
	input  minibus_pkg::word_t       reg_rdata_i,
	output minibus_pkg::bus_req_t    req_o,
	output minibus_pkg::word_t       cpu_data_o,
	output logic                     dtack_n_o
);
	import minibus_pkg::*;

	// peripheral strobe goes one clock ahead so dtack lands on the ack phase
	localparam eclk_phase_t ECLK_STB = eclk_phase_t'(ECLK_ACK - 4'd1);

	cpu_ctrl_t  l_ctrl;            // sampled cpu strobes
	bus_state_e state_q, state_d;
	logic       lvpa;              // cia access pending, latched
	logic       vma;               // valid memory address, e-clock aligned
	logic       stb;               // the one strobe cycle of this access
	logic       dtack_q;
	word_t      rdata_q;           // read data held for the cpu

	//------------------------------------------------
	// input sampling
	//------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpurst) begin
			l_ctrl <= '1;  // as_n high, read
		end else begin
			l_ctrl <= cpu_ctrl_i;
		end
	end

	// vpa/vma pair for cia cycles
	always_ff @(posedge clk) begin
		if (cpurst) begin
			lvpa <= 1'b0;
			vma  <= 1'b0;
		end else begin
			lvpa <= (state_q == ST_ECLK_WAIT);
			if (phase_i == ECLK_VMA_CLR)
				vma <= 1'b0;
			else if (phase_i == ECLK_VMA_SET && lvpa)
				vma <= 1'b1;  // only when the access was already waiting
		end
	end

	//------------------------------------------------
	// bus cycle fsm
	//------------------------------------------------
	// memory and custom: first cck-low clock, cia: phase before ack with vma
	assign stb = !l_ctrl.as_n &&
		((state_q == ST_SLOT && !cck_i) ||
		 (state_q == ST_ECLK_WAIT && vma && phase_i == ECLK_STB));

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (!l_ctrl.as_n)
					state_d = (region_i == RGN_CIA) ? ST_ECLK_WAIT : ST_SLOT;
			end
			ST_SLOT, ST_ECLK_WAIT: begin
				if (l_ctrl.as_n)
					state_d = ST_IDLE;  // cpu gave up, no strobe issued
				else if (stb)
					state_d = ST_ACK;
			end
			ST_ACK: begin
				if (l_ctrl.as_n)
					state_d = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (cpurst) begin
			state_q <= ST_IDLE;
			dtack_q <= 1'b1;
		end else begin
			state_q <= state_d;
			dtack_q <= (state_d != ST_ACK);  // low for the whole ack state
		end
	end

	// read data, merged from sram and registers in the strobe clock
	always_ff @(posedge clk) begin
		if (stb && l_ctrl.r_w)
			rdata_q <= mem_rdata_i | reg_rdata_i;
	end

	//------------------------------------------------
	// internal request
	//------------------------------------------------
	always_comb begin
		req_o.addr  = cpu_addr_i;
		req_o.wdata = cpu_wdata_i;
		req_o.rd    = stb & l_ctrl.r_w;
		req_o.hwr   = stb & ~l_ctrl.r_w & ~l_ctrl.uds_n;
		req_o.lwr   = stb & ~l_ctrl.r_w & ~l_ctrl.lds_n;
	end

	assign cpu_data_o = rdata_q;
	assign dtack_n_o  = dtack_q;

endmodule

//--- verilog/memory_bank_decoder.sv
//------------------------------------------------
// address decode, 512 KB bank mapping for the
// sixteen memory configurations and sram strobes
//------------------------------------------------
`timescale 1ns/1ps

module memory_bank_decoder #(
	parameter bit ECS_BANKS = 1'b1  // ecs keeps chip blocks 1/3 off bank 0
) (
	input  minibus_pkg::bus_req_t    req_i,
	input  minibus_pkg::mem_config_t mem_config_i,
	input  minibus_pkg::word_t       ram_data_i,
	output minibus_pkg::region_e     region_o,
	output minibus_pkg::bank_sel_t   bank_o,
	output minibus_pkg::ram_ctrl_t   ram_o,
	output minibus_pkg::word_t       ram_wdata_o,
	output minibus_pkg::word_t       mem_rdata_o
);
	import minibus_pkg::*;

	logic [7:0] top_byte;    // a[23:16]
	logic [1:0] blk;         // 512 KB block within the region
	region_e    region;
	logic [3:0] chip;        // chip block selects
	logic [2:0] slow;        // slow block selects
	logic       kick;
	bank_sel_t  bank;
	logic       ram_en;

	assign top_byte = req_i.addr[23:16];
	assign blk      = req_i.addr[20:19];

	//------------------------------------------------
	// region decode
	//------------------------------------------------
	always_comb begin
		if (top_byte <= ADDR_CHIP_HI)
			region = RGN_CHIP;
		else if (top_byte >= ADDR_SLOW_LO && top_byte <= ADDR_SLOW_HI)
			region = RGN_SLOW;
		else if (top_byte == ADDR_CIA)
			region = RGN_CIA;
		else if (top_byte == ADDR_CUSTOM)
			region = RGN_CUSTOM;
		else if (top_byte >= ADDR_KICK_LO)
			region = RGN_KICK;
		else
			region = RGN_NONE;
	end

	assign chip = (region == RGN_CHIP) ? (4'b0001 << blk) : 4'b0000;
	assign slow = (region == RGN_SLOW) ? (3'b001 << blk) : 3'b000;  // C0/C8/D0
	assign kick = (region == RGN_KICK);

	//------------------------------------------------
	// bank table, kick always on bank 3
	//------------------------------------------------
	always_comb begin
		case (mem_config_i)
			4'h0: bank = {4'b0000, kick, 1'b0, 1'b0, |chip};                  // 0.5 chip
			4'h1: bank = {4'b0000, kick, 1'b0, chip[1] | chip[3], chip[0] | chip[2]};
			4'h2: bank = {4'b0000, kick, chip[2], chip[1], chip[0]};          // 1.5 chip
			4'h3: bank = {2'b00, chip[3], 1'b0, kick, chip[2], chip[1], chip[0]};
			4'h4: bank = {4'b0000, kick, slow[0], 1'b0,
				chip[0] | (chip[1] & ~ECS_BANKS) | chip[2] |
				(chip[3] & ~ECS_BANKS)};                                       // 0.5 + 0.5
			4'h5: bank = {4'b0000, kick, slow[0], chip[1] | chip[3], chip[0] | chip[2]};
			4'h6: bank = {3'b000, slow[0], kick, chip[2], chip[1], chip[0]};
			4'h7: bank = {2'b00, chip[3], slow[0], kick, chip[2], chip[1], chip[0]};
			4'h8: bank = {4'b0000, kick, slow[0], slow[1], |chip};            // 0.5 + 1.0
			4'h9: bank = {2'b00, slow[1], 1'b0, kick, slow[0], chip[1] | chip[3],
				chip[0] | chip[2]};
			4'hA: bank = {2'b00, slow[1], slow[0], kick, chip[2], chip[1], chip[0]};
			4'hB: bank = {slow[1], 1'b0, chip[3], slow[0], kick, chip[2], chip[1], chip[0]};
			4'hC: bank = {3'b000, slow[2], kick, slow[0], slow[1], |chip};    // 0.5 + 1.5
			4'hD: bank = {2'b00, slow[1], slow[2], kick, slow[0], chip[1] | chip[3],
				chip[0] | chip[2]};
			4'hE: bank = {1'b0, slow[2], slow[1], slow[0], kick, chip[2], chip[1], chip[0]};
			default: bank = {slow[1], slow[2], chip[3], slow[0], kick,
				chip[2], chip[1], chip[0]};                                    // 2.0 + 1.5
		endcase
	end

	//------------------------------------------------
	// sram strobes, all high when nothing is mapped
	//------------------------------------------------
	assign ram_en = |bank;

	always_comb begin
		ram_o.addr  = req_i.addr[18:1];
		ram_o.we_n  = ~(req_i.hwr | req_i.lwr) | ~ram_en;
		ram_o.oe_n  = ~req_i.rd | ~ram_en;
		ram_o.bhe_n = ~req_i.hwr | ~ram_en;  // byte lanes only qualify writes
		ram_o.ble_n = ~req_i.lwr | ~ram_en;
	end

	assign mem_rdata_o = (~req_i.rd | ~ram_en) ? '0 : ram_data_i;  // zero unless oe active
	assign ram_wdata_o = req_i.wdata;
	assign region_o    = region;
	assign bank_o      = bank;

endmodule

//--- verilog/user_port_regs.sv
//------------------------------------------------
// user port registers: mouse quadrature counters,
// joystick position and potgo/potinp in custom space
//------------------------------------------------
`timescale 1ns/1ps

module user_port_regs (
	input  logic                  clk,
	input  logic                  cpurst,
	input  minibus_pkg::bus_req_t req_i,
	input  minibus_pkg::region_e  region_i,
	input  logic [5:0]            mouse_i,   // [5] right button, [3:2] x, [1:0] y
	input  logic [5:0]            joy1_n_i,  // [fire2,fire,up,left,down,right]
	input  logic [5:0]            joy2_n_i,
	output minibus_pkg::word_t    reg_rdata_o
);
	import minibus_pkg::*;

	logic [3:0]      mouse_d;     // first sample
	logic [3:0]      mouse_d2;    // second sample, previous line state
	logic [1:0]      cnt_en;      // [0] x, [1] y
	logic [1:0]      cnt_up;
	logic [1:0][7:0] mouse_cnt;   // {y, x}
	logic [7:0]      js_x, js_y;
	word_t           pot_q;       // potgo
	word_t           pot_in;
	logic            reg_sel;
	logic [8:1]      reg_off;

	//------------------------------------------------
	// mouse quadrature
	//------------------------------------------------
	always_ff @(posedge clk) begin
		mouse_d  <= mouse_i[3:0];
		mouse_d2 <= mouse_d;
	end

	// one line changed: count; new a vs old b gives direction
	assign cnt_en[0] = ^{mouse_d[3:2], mouse_d2[3:2]};
	assign cnt_en[1] = ^{mouse_d[1:0], mouse_d2[1:0]};
	assign cnt_up[0] = mouse_d[2] ^ mouse_d2[3];
	assign cnt_up[1] = mouse_d[0] ^ mouse_d2[1];

	always_ff @(posedge clk) begin
		if (cpurst) begin
			mouse_cnt <= '0;
		end else begin
			for (int a = 0; a < 2; a++) begin
				if (cnt_en[a])
					mouse_cnt[a] <= cnt_up[a] ? mouse_cnt[a] + 8'd1 : mouse_cnt[a] - 8'd1;
			end
		end
	end

	//------------------------------------------------
	// joystick and pot registers
	//------------------------------------------------
	// counter style position, bit 1 = !right/!down, bit 0 = that xor left/up
	assign js_x = {6'b000000, ~joy2_n_i[0], joy2_n_i[2] ^ joy2_n_i[0]};
	assign js_y = {6'b000000, ~joy2_n_i[1], joy2_n_i[3] ^ joy2_n_i[1]};

	assign reg_sel = (region_i == RGN_CUSTOM);
	assign reg_off = req_i.addr[8:1];

	always_ff @(posedge clk) begin
		if (cpurst) begin
			pot_q <= '0;
		end else if (reg_sel && reg_off == REG_POTGO[8:1]) begin
			if (req_i.hwr)
				pot_q[15:8] <= req_i.wdata[15:8];
			if (req_i.lwr)
				pot_q[7:0] <= req_i.wdata[7:0];
		end
	end

	// pot pins read back the driven potgo bits, pulled low by pressed buttons
	assign pot_in = {1'b0, joy2_n_i[5] & pot_q[14], 1'b0, pot_q[12],
		1'b0, pot_q[10] & ~mouse_i[5] & joy1_n_i[5], 1'b0, pot_q[8], 8'h00};

	always_comb begin
		reg_rdata_o = '0;  // zero keeps the read merge an or
		if (reg_sel) begin
			case (reg_off)
				REG_JOY0DAT[8:1]: reg_rdata_o = {mouse_cnt[1], mouse_cnt[0]};
				REG_JOY1DAT[8:1]: reg_rdata_o = {js_y, js_x};
				REG_POTINP[8:1]:  reg_rdata_o = pot_in;
				default:          reg_rdata_o = '0;
			endcase
		end
	end

endmodule

//--- verilog/minibus_top.sv
//------------------------------------------------
// cpu side core: bus bridge, e-clock timer, bank
// mapper and user port registers wired together
//------------------------------------------------
`timescale 1ns/1ps

module minibus_top #(
	parameter bit ECS_BANKS = 1'b1
) (
	input  logic                     clk,
	input  logic                     cpurst,
	// 68000 side
	input  minibus_pkg::cpu_ctrl_t   cpu_ctrl_i,
	input  minibus_pkg::cpu_addr_t   cpu_addr_i,
	input  minibus_pkg::word_t       cpu_wdata_i,
	output minibus_pkg::word_t       cpu_data_o,
	output logic                     cpu_dtack_n_o,
	// sram side
	input  minibus_pkg::mem_config_t mem_config_i,
	input  minibus_pkg::word_t       ram_data_i,
	output minibus_pkg::ram_ctrl_t   ram_o,
	output minibus_pkg::word_t       ram_wdata_o,
	output minibus_pkg::bank_sel_t   bank_o,
	// user port
	input  logic [5:0]               mouse_i,
	input  logic [5:0]               joy1_n_i,
	input  logic [5:0]               joy2_n_i
);
	import minibus_pkg::*;

	eclk_phase_t phase;
	logic        cck;
	bus_req_t    bus_req;
	region_e     region;
	word_t       mem_rdata;
	word_t       reg_rdata;  // zero outside the user registers

	eclk_timer u_eclk (
		.clk     (clk),
		.cpurst  (cpurst),
		.phase_o (phase),
		.cck_o   (cck)
	);

	cpu_bus_fsm u_bus (
		.clk         (clk),
		.cpurst      (cpurst),
		.cpu_ctrl_i  (cpu_ctrl_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.phase_i     (phase),
		.cck_i       (cck),
		.region_i    (region),
		.mem_rdata_i (mem_rdata),
		.reg_rdata_i (reg_rdata),
		.req_o       (bus_req),
		.cpu_data_o  (cpu_data_o),
		.dtack_n_o   (cpu_dtack_n_o)
	);

	memory_bank_decoder #(
		.ECS_BANKS (ECS_BANKS)
	) u_dec (
		.req_i        (bus_req),
		.mem_config_i (mem_config_i),
		.ram_data_i   (ram_data_i),
		.region_o     (region),
		.bank_o       (bank_o),
		.ram_o        (ram_o),
		.ram_wdata_o  (ram_wdata_o),
		.mem_rdata_o  (mem_rdata)
	);

	user_port_regs u_uport (
		.clk         (clk),
		.cpurst      (cpurst),
		.req_i       (bus_req),
		.region_i    (region),
		.mouse_i     (mouse_i),
		.joy1_n_i    (joy1_n_i),
		.joy2_n_i    (joy2_n_i),
		.reg_rdata_o (reg_rdata)
	);

endmodule

//--- verification/minibus_tb.sv
//------------------------------------------------
// testbench for the cpu side core: bank mapping,
// sram cycles, mouse, joystick, potgo and cia timing
//------------------------------------------------
`timescale 1ns/1ps

module minibus_tb;
	import minibus_pkg::*;

	localparam bit ECS_BANKS   = 1'b1;
	localparam int ACK_TIMEOUT = 30;    // cycles allowed from as_n low to dtack
	localparam int N_RAM       = 64;
	localparam int N_MOUSE     = 48;
	localparam int N_JOY       = 8;
	localparam int N_CIA       = 4;
	// about 1400 cycles expected, worst case cia waits fit well below this
	localparam int MAX_CYCLES  = 4000;

	logic        clk;
	logic        cpurst;
	cpu_ctrl_t   cpu_ctrl_i;
	cpu_addr_t   cpu_addr_i;
	word_t       cpu_wdata_i;
	word_t       cpu_data_o;
	logic        cpu_dtack_n_o;
	mem_config_t mem_config_i;
	word_t       ram_data_i;
	ram_ctrl_t   ram_o;
	word_t       ram_wdata_o;
	bank_sel_t   bank_o;
	logic [5:0]  mouse_i;
	logic [5:0]  joy1_n_i;
	logic [5:0]  joy2_n_i;

	integer      seed;
	int          cycles;
	int          eclk_count;   // phase model, counted from reset release
	logic [31:0] r, r2;
	mem_config_t cfg;
	logic [7:0]  top;
	logic [1:0]  lanes;
	cpu_addr_t   a;
	word_t       d, w, potgo;
	int          ph;
	logic        mapped;
	logic [3:0]  mlines, nxt;
	logic [7:0]  cnt_x, cnt_y;
	ram_ctrl_t   exp_ram;

	minibus_top #(
		.ECS_BANKS (ECS_BANKS)
	) i_dut (
		.clk           (clk),
		.cpurst        (cpurst),
		.cpu_ctrl_i    (cpu_ctrl_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_wdata_i   (cpu_wdata_i),
		.cpu_data_o    (cpu_data_o),
		.cpu_dtack_n_o (cpu_dtack_n_o),
		.mem_config_i  (mem_config_i),
		.ram_data_i    (ram_data_i),
		.ram_o         (ram_o),
		.ram_wdata_o   (ram_wdata_o),
		.bank_o        (bank_o),
		.mouse_i       (mouse_i),
		.joy1_n_i      (joy1_n_i),
		.joy2_n_i      (joy2_n_i)
	);

	always #2 clk = ~clk;  // 4 ns period

	//------------------------------------------------
	// run limit and e-clock phase model
	//------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_on_error($sformatf("timeout: run went past %0d cycles", MAX_CYCLES));
	end

	always @(posedge clk) begin
		if (cpurst)
			eclk_count <= 0;
		else
			eclk_count <= (eclk_count == ECLK_PHASES - 1) ? 0 : eclk_count + 1;
	end

	//------------------------------------------------
	// reference functions
	//------------------------------------------------
	function automatic cpu_addr_t word_addr(input logic [23:0] b);
		word_addr = b[23:1];
	endfunction

	function automatic cpu_addr_t custom_addr(input logic [8:0] off);
		logic [23:0] b;
		b = {ADDR_CUSTOM, 16'hF000} | {15'b0, off};
		custom_addr = b[23:1];
	endfunction

	// bank index per region, chip size cfg[1:0], slow size cfg[3:2]
	function automatic bank_sel_t bank_ref(input mem_config_t c, input cpu_addr_t ad);
		logic [7:0] tb;
		int         blk, csz, ssz, idx;
		tb = ad[23:16];
		blk = ad[20:19];
		csz = c[1:0];
		ssz = c[3:2];
		idx = -1;
		if (tb <= ADDR_CHIP_HI) begin
			case (csz)
				0: idx = (ECS_BANKS && ssz == 1 && blk % 2 == 1) ? -1 : 0;  // all fold on 0
				1: idx = blk % 2;
				2: idx = (blk == 3) ? -1 : blk;
				default: idx = (blk == 3) ? 5 : blk;
			endcase
		end else if (tb >= ADDR_SLOW_LO && tb <= ADDR_SLOW_HI) begin
			if (blk < ssz) begin
				case (blk)
					0: idx = (csz < 2) ? 2 : 4;
					1: idx = (csz == 0) ? 1 : ((csz == 3) ? 7 : 5);
					default: idx = (csz < 2) ? 4 : 6;
				endcase
			end
		end else if (tb >= ADDR_KICK_LO) begin
			idx = 3;
		end
		bank_ref = '0;
		if (idx >= 0)
			bank_ref[idx] = 1'b1;
	endfunction

	// pair is {b, a}; one line change counts, up when new a differs from old b
	function automatic logic [7:0] mouse_count(input logic [7:0] cnt, input logic [1:0] old_ba,
		input logic [1:0] new_ba);
		logic [1:0] diff;
		diff = old_ba ^ new_ba;
		mouse_count = cnt;
		if (diff == 2'b01 || diff == 2'b10)
			mouse_count = (new_ba[0] != old_ba[1]) ? cnt + 8'd1 : cnt - 8'd1;
	endfunction

	function automatic word_t joy_pos(input logic [5:0] j_n);
		logic [1:0] x, y;
		x = {~j_n[0], j_n[0] ^ j_n[2]};  // right, left
		y = {~j_n[1], j_n[1] ^ j_n[3]};  // down, up
		joy_pos = {6'b0, y, 6'b0, x};
	endfunction

	function automatic word_t potinp_ref(input word_t pg, input logic fire2_n,
		input logic j1_fire2_n, input logic mouse_rb);
		potinp_ref = '0;
		potinp_ref[14] = pg[14] & fire2_n;
		potinp_ref[12] = pg[12];
		potinp_ref[10] = pg[10] & j1_fire2_n & ~mouse_rb;  // both right buttons up
		potinp_ref[8]  = pg[8];
	endfunction

	//------------------------------------------------
	// compare tasks
	//------------------------------------------------
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bank(input string name, input bank_sel_t exp, input bank_sel_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_ram(input string name, input ram_ctrl_t exp, input ram_ctrl_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	//------------------------------------------------
	// one 68000 bus cycle, strobes watched every clock
	//------------------------------------------------
	task automatic bus_access(input string name, input cpu_addr_t addr, input logic rd,
		input logic u_n, input logic l_n, input word_t wdata, input word_t rword,
		input logic map, output word_t rdata, output int ack_phase);
		cpu_ctrl_t ctrl;
		ram_ctrl_t exp_idle, exp_act, act;
		int        strobes, waited;
		logic      acked;
		ctrl.as_n = 1'b0;
		ctrl.uds_n = u_n;
		ctrl.lds_n = l_n;
		ctrl.r_w = rd;
		exp_idle.addr = addr[18:1];
		exp_idle.we_n = 1'b1;
		exp_idle.oe_n = 1'b1;
		exp_idle.bhe_n = 1'b1;
		exp_idle.ble_n = 1'b1;
		exp_act.addr = addr[18:1];
		exp_act.we_n = rd | (u_n & l_n);
		exp_act.oe_n = ~rd;
		exp_act.bhe_n = rd | u_n;       // lanes qualify writes only
		exp_act.ble_n = rd | l_n;
		strobes = 0;
		waited = 0;
		acked = 1'b0;
		@(posedge clk);
		cpu_addr_i <= addr;
		cpu_wdata_i <= wdata;
		ram_data_i <= rword;
		cpu_ctrl_i <= ctrl;
		while (!acked) begin
			@(negedge clk);
			waited++;
			act = ram_o;
			if (act.we_n & act.oe_n & act.bhe_n & act.ble_n) begin
				check_ram(name, exp_idle, act);
			end else begin
				strobes++;
				check_ram(name, exp_act, act);
				if (!rd)
					check_word($sformatf("%s wdata", name), wdata, ram_wdata_o);  // at the pulse
			end
			if (cpu_dtack_n_o === 1'b0)
				acked = 1'b1;
			else if (waited >= ACK_TIMEOUT)
				stop_on_error($sformatf("%s: dtack did not come within %0d cycles", name,
					ACK_TIMEOUT));
		end
		rdata = cpu_data_o;
		ack_phase = eclk_count;
		if (strobes != (map ? 1 : 0))
			stop_on_error($sformatf("%s: saw %0d sram strobe cycles", name, strobes));
		if (addr[23:16] == ADDR_CIA) begin
			if (ack_phase != ECLK_ACK)
				stop_on_error($sformatf("%s: cia dtack fell in phase %0d", name, ack_phase));
		end else if (ack_phase % 2 != 0) begin
			stop_on_error($sformatf("%s: dtack fell with cck low", name));
		end
		@(posedge clk);
		cpu_ctrl_i <= '1;  // as_n back high
		waited = 0;
		while (cpu_dtack_n_o !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > 4)
				stop_on_error($sformatf("%s: dtack stayed low after as_n rose", name));
		end
	endtask

	task automatic read_reg(input string name, input logic [8:0] off, output word_t rdata);
		logic [31:0] rr;
		int          p;
		rr = $random(seed);
		// sram data on the bus must not leak into register reads
		bus_access(name, custom_addr(off), 1'b1, 1'b0, 1'b0, 16'h0, rr[15:0], 1'b0, rdata, p);
	endtask

	//------------------------------------------------
	// stimulus
	//------------------------------------------------
	initial begin
		seed = 32'hd739_d9f5;
		clk = 1'b0;
		cycles = 0;
		cpurst = 1'b1;
		cpu_ctrl_i = '1;
		cpu_addr_i = '0;
		cpu_wdata_i = '0;
		mem_config_i = 4'hF;
		ram_data_i = '0;
		mouse_i = 6'h00;   // right button released
		joy1_n_i = 6'h3F;
		joy2_n_i = 6'h3F;
		repeat (8) @(posedge clk);
		cpurst <= 1'b0;
		@(posedge clk);

		// reset state
		@(negedge clk);
		if (cpu_dtack_n_o !== 1'b1)
			stop_on_error("reset: dtack is not high after reset");
		exp_ram.addr = cpu_addr_i[18:1];
		exp_ram.we_n = 1'b1;
		exp_ram.oe_n = 1'b1;
		exp_ram.bhe_n = 1'b1;
		exp_ram.ble_n = 1'b1;
		check_ram("reset ram strobes", exp_ram, ram_o);
		read_reg("reset joy0dat", REG_JOY0DAT, d);
		check_word("reset joy0dat", 16'h0000, d);

		// bank table, as_n stays high
		for (int c = 0; c < 16; c++) begin
			for (int k = 0; k < 9; k++) begin
				r = $random(seed);
				if (k < 4)
					top = {3'b000, k[1:0], r[2:0]};           // chip blocks
				else if (k < 7)
					top = ADDR_SLOW_LO + 8'((k - 4) * 8) + {5'b0, r[2:0]};
				else if (k == 7)
					top = ADDR_KICK_LO | {5'b0, r[2:0]};
				else
					top = 8'h40;                              // nothing there
				a = word_addr({top, r[31:16]});
				@(posedge clk);
				mem_config_i <= mem_config_t'(c);
				cpu_addr_i <= a;
				@(negedge clk);
				check_bank($sformatf("bank cfg %h top %h", c, top),
					bank_ref(mem_config_t'(c), a), bank_o);
			end
		end

		// random sram cycles
		for (int i = 0; i < N_RAM; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			cfg = r[3:0];
			case (r[5:4])
				2'd0: top = {3'b000, r[10:6]};
				2'd1: top = ADDR_SLOW_LO + 8'(r[10:6] % 24);
				2'd2: top = ADDR_KICK_LO | {5'b0, r[8:6]};
				default: top = 8'h20 + {1'b0, r[12:6]};      // 20..9f unmapped
			endcase
			a = word_addr({top, r2[31:16]});
			mapped = (bank_ref(cfg, a) != '0);
			lanes = (r[15:14] == 2'b11) ? 2'b00 : r[15:14];
			@(posedge clk);
			mem_config_i <= cfg;
			bus_access($sformatf("ram cfg %h addr %h", cfg, a), a, r[13], lanes[1], lanes[0],
				r[31:16], r2[15:0], mapped, d, ph);
			if (r[13])
				check_word($sformatf("ram read cfg %h addr %h", cfg, a),
					mapped ? r2[15:0] : 16'h0000, d);
		end

		// mouse quadrature
		mlines = 4'b0000;
		cnt_x = 8'h00;
		cnt_y = 8'h00;
		for (int i = 0; i < N_MOUSE; i++) begin
			r = $random(seed);
			nxt = mlines;
			if (r[1:0] == 2'd1)
				nxt[2] = ~nxt[2];  // x a
			else if (r[1:0] == 2'd2)
				nxt[3] = ~nxt[3];  // x b
			if (r[3:2] == 2'd1)
				nxt[0] = ~nxt[0];
			else if (r[3:2] == 2'd2)
				nxt[1] = ~nxt[1];
			cnt_x = mouse_count(cnt_x, mlines[3:2], nxt[3:2]);
			cnt_y = mouse_count(cnt_y, mlines[1:0], nxt[1:0]);
			mlines = nxt;
			@(posedge clk);
			mouse_i[3:0] <= nxt;
			repeat (2) @(posedge clk);  // through both sync stages
			if (i % 12 == 11) begin
				repeat (3) @(posedge clk);
				read_reg("joy0dat mouse", REG_JOY0DAT, d);
				check_word("joy0dat mouse", {cnt_y, cnt_x}, d);
			end
		end

		// joystick position and potgo
		potgo = 16'h0000;
		for (int i = 0; i < N_JOY; i++) begin
			r = $random(seed);
			@(posedge clk);
			joy2_n_i <= r[5:0];
			joy1_n_i <= {r[6], 5'h1F};
			mouse_i[5] <= r[7];
			read_reg("joy1dat", REG_JOY1DAT, d);
			check_word("joy1dat", joy_pos(r[5:0]), d);
			lanes = (r[9:8] == 2'b11) ? 2'b00 : r[9:8];
			w = r[31:16];
			bus_access("potgo write", custom_addr(REG_POTGO), 1'b0, lanes[1], lanes[0], w,
				16'h0000, 1'b0, d, ph);
			if (!lanes[1])
				potgo[15:8] = w[15:8];
			if (!lanes[0])
				potgo[7:0] = w[7:0];
			read_reg("potinp", REG_POTINP, d);
			check_word("potinp", potinp_ref(potgo, r[5], r[6], r[7]), d);
		end

		// cia reads, started in varying e-clock phases
		for (int i = 0; i < N_CIA; i++) begin
			r = $random(seed);
			repeat (r[3:0]) @(posedge clk);
			bus_access("cia read", word_addr(24'hBFE001), 1'b1, r[4], ~r[4], 16'h0000,
				r[31:16], 1'b0, d, ph);
			check_word("cia read data", 16'h0000, d);
		end

		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- minibus.f
verilog/minibus_pkg.sv
verilog/eclk_timer.sv
verilog/cpu_bus_fsm.sv
verilog/memory_bank_decoder.sv
verilog/user_port_regs.sv
verilog/minibus_top.sv
verification/minibus_tb.sv

//--- Bender.yml
package:
  name: minibus

sources:
  - verilog/minibus_pkg.sv
  - verilog/eclk_timer.sv
  - verilog/cpu_bus_fsm.sv
  - verilog/memory_bank_decoder.sv
  - verilog/user_port_regs.sv
  - verilog/minibus_top.sv
  - target: test
    files:
      - verification/minibus_tb.sv
